// File: source/lab_pkg.sv
package lab_pkg;

    // **************************************************
    // widths shared by the design and the testbench
    // **************************************************

    localparam int SHIFT_W      = 12; // one register bit per board led.
    localparam int STROBE_CNT_W = 16; // upper four digits of the display.
    localparam int FSM_CNT_W    = 8;  // two digits per detector count.
    localparam int DIGITS       = 8;  // digits on the multiplexed display.

    // default strobe widths for a 50 MHz board clock
    localparam int SHIFT_STROBE_W_DEF = 23; // roughly six shifts per second.
    localparam int SCAN_STROBE_W_DEF  = 10; // fast enough to avoid visible flicker.

    // **************************************************
    // display word and detector states
    // **************************************************

    typedef struct packed {
        logic [STROBE_CNT_W-1:0] strobe_count; // digits 7 down to 4.
        logic [FSM_CNT_W-1:0]    moore_count;  // digits 3 and 2.
        logic [FSM_CNT_W-1:0]    mealy_count;  // digits 1 and 0.
    } display_word_t;

    typedef enum logic [1:0] {
        MOORE_IDLE    = 2'd0, // no useful prefix seen.
        MOORE_GOT_1   = 2'd1, // last bit was 1.
        MOORE_GOT_10  = 2'd2, // last two bits were 1 then 0.
        MOORE_GOT_101 = 2'd3  // full pattern seen, output is high.
    } moore_state_t;

    typedef enum logic [1:0] {
        MEALY_IDLE   = 2'd0, // no useful prefix seen.
        MEALY_GOT_1  = 2'd1, // last bit was 1.
        MEALY_GOT_10 = 2'd2  // a 1 now completes the pattern.
    } mealy_state_t;

endpackage

// File: source/strobe_gen.sv
`timescale 1ns/10ps

module strobe_gen #(
    parameter int W = 4 // the period is 2**W clock cycles.
) (
    input  logic i_clk,
    input  logic i_arst_n,
    output logic o_strobe
);

    logic [W-1:0] cnt; // free running, wraps on its own.

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt      <= '0;
            o_strobe <= 1'b0; // quiet during reset.
        end else begin
            cnt      <= cnt + W'(1);
            o_strobe <= &cnt; // registered, so the pulse is one clean cycle.
        end
    end

    // the first pulse appears on the edge after cnt reaches all ones,
    // which is exactly 2**W cycles after reset is released.

endmodule

// File: source/shift_register.sv
`timescale 1ns/10ps

module shift_register (
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_en,
    input  logic                        i_in,
    output logic [lab_pkg::SHIFT_W-1:0] o_out_reg
);

    import lab_pkg::*;

    // bit 0 always holds the newest bit, older bits move toward the msb.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_out_reg <= '0; // all leds dark after reset.
        end else if (i_en) begin
            o_out_reg <= {o_out_reg[SHIFT_W-2:0], i_in}; // oldest bit drops out.
        end
    end

endmodule

// File: source/moore_fsm.sv
`timescale 1ns/10ps

module moore_fsm (
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_en,
    input  logic i_a,
    output logic o_y
);

    import lab_pkg::*;

    moore_state_t state;      // current state, changes only on i_en.
    moore_state_t state_next; // combinational next state.

    // **************************************************
    // next state for 1-0-1 with overlap
    // **************************************************

    always_comb begin
        state_next = state; // hold unless a case below moves it.
        case (state)
            MOORE_IDLE:    state_next = i_a ? MOORE_GOT_1   : MOORE_IDLE;
            MOORE_GOT_1:   state_next = i_a ? MOORE_GOT_1   : MOORE_GOT_10;
            MOORE_GOT_10:  state_next = i_a ? MOORE_GOT_101 : MOORE_IDLE;
            MOORE_GOT_101: state_next = i_a ? MOORE_GOT_1   : MOORE_GOT_10; // overlap.
            default:       state_next = MOORE_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= MOORE_IDLE;
        end else if (i_en) begin
            state <= state_next; // advance once per shift strobe.
        end
    end

    // the output comes from the state only, one strobe after the last bit.
    assign o_y = (state == MOORE_GOT_101);

endmodule

// File: source/mealy_fsm.sv
`timescale 1ns/10ps

module mealy_fsm (
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_en,
    input  logic i_a,
    output logic o_y
);

    import lab_pkg::*;

    mealy_state_t state;      // current state, changes only on i_en.
    mealy_state_t state_next; // combinational next state.

    // **************************************************
    // next state for 1-0-1 with overlap
    // **************************************************

    always_comb begin
        state_next = state; // hold unless a case below moves it.
        case (state)
            MEALY_IDLE:   state_next = i_a ? MEALY_GOT_1 : MEALY_IDLE;
            MEALY_GOT_1:  state_next = i_a ? MEALY_GOT_1 : MEALY_GOT_10;
            MEALY_GOT_10: state_next = i_a ? MEALY_GOT_1 : MEALY_IDLE; // a hit keeps its 1.
            default:      state_next = MEALY_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= MEALY_IDLE;
        end else if (i_en) begin
            state <= state_next; // advance once per shift strobe.
        end
    end

    // the output reacts to the input directly, a strobe ahead of the moore one.
    assign o_y = (state == MEALY_GOT_10) && i_a;

endmodule

// File: source/event_counters.sv
`timescale 1ns/10ps

module event_counters (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  logic                   i_en,
    input  logic                   i_moore_y,
    input  logic                   i_mealy_y,
    output lab_pkg::display_word_t o_word
);

    import lab_pkg::*;

    // **************************************************
    // counters written straight into the display word
    // **************************************************

    // each detector output only counts when sampled on the shift strobe,
    // otherwise a high output would be counted on every clock cycle.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_word <= '0; // display reads all zeros after reset.
        end else if (i_en) begin
            o_word.strobe_count <= o_word.strobe_count + STROBE_CNT_W'(1); // every strobe.

            if (i_moore_y) begin
                o_word.moore_count <= o_word.moore_count + FSM_CNT_W'(1); // trails by one.
            end

            if (i_mealy_y) begin
                o_word.mealy_count <= o_word.mealy_count + FSM_CNT_W'(1); // same strobe as the bit.
            end
        end
    end

    // all three fields wrap at their natural width.

endmodule

// File: source/seven_segment.sv
`timescale 1ns/10ps

module seven_segment (
    input  logic                       i_clk,
    input  logic                       i_arst_n,
    input  logic                       i_en,
    input  lab_pkg::display_word_t     i_word,
    input  logic [lab_pkg::DIGITS-1:0] i_dots,
    output logic [6:0]                 o_abcdefg,
    output logic                       o_dot,
    output logic [lab_pkg::DIGITS-1:0] o_anodes
);

    import lab_pkg::*;

    logic [$clog2(DIGITS)-1:0]        index;     // digit being shown.
    logic                             scan_on;   // set by the first scan strobe.
    logic [$bits(display_word_t)-1:0] word_bits; // flat view of the word.
    logic [3:0]                       nibble;    // hex value of the current digit.

    // active high segments with a in bit 6 and g in bit 0.
    function automatic logic [6:0] hex_to_seg(input logic [3:0] value);
        logic [6:0] seg;
        case (value)
            4'h0:    seg = 7'b1111110;
            4'h1:    seg = 7'b0110000;
            4'h2:    seg = 7'b1101101;
            4'h3:    seg = 7'b1111001;
            4'h4:    seg = 7'b0110011;
            4'h5:    seg = 7'b1011011;
            4'h6:    seg = 7'b1011111;
            4'h7:    seg = 7'b1110000;
            4'h8:    seg = 7'b1111111;
            4'h9:    seg = 7'b1111011;
            4'ha:    seg = 7'b1110111;
            4'hb:    seg = 7'b0011111; // lower case b so it differs from 8.
            4'hc:    seg = 7'b1001110;
            4'hd:    seg = 7'b0111101; // lower case d so it differs from 0.
            4'he:    seg = 7'b1001111;
            default: seg = 7'b1000111; // f.
        endcase
        return seg;
    endfunction

    // **************************************************
    // digit scan
    // **************************************************

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            index   <= '0;
            scan_on <= 1'b0; // keeps the display dark until the first strobe.
        end else if (i_en) begin
            index   <= index + 3'd1; // wraps from 7 back to 0.
            scan_on <= 1'b1;
        end
    end

    assign word_bits = i_word;                  // digit 0 is the lowest nibble.
    assign nibble    = word_bits[index * 4 +: 4];

    // **************************************************
    // registered active low outputs
    // **************************************************

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_abcdefg <= '1; // segments off.
            o_dot     <= 1'b1;
            o_anodes  <= '1; // no digit selected.
        end else if (scan_on) begin
            o_abcdefg <= ~hex_to_seg(nibble);       // active low segments.
            o_dot     <= ~i_dots[index];            // lit when its dot bit is set.
            o_anodes  <= ~(DIGITS'(1) << index);    // one cold anode.
        end
    end

endmodule

// File: source/lab_top.sv
`timescale 1ns/10ps

module lab_top #(
    parameter int SHIFT_STROBE_W = lab_pkg::SHIFT_STROBE_W_DEF,
    parameter int SCAN_STROBE_W  = lab_pkg::SCAN_STROBE_W_DEF
) (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  logic [3:0]                  i_key,
    input  logic [lab_pkg::DIGITS-1:0]  i_sw,
    output logic [lab_pkg::SHIFT_W-1:0] o_led,
    output logic [7:0]                  o_abcdefgh,
    output logic [lab_pkg::DIGITS-1:0]  o_digit,
    output logic                        o_buzzer
);

    import lab_pkg::*;

    logic               serial_bit;   // key 1 pressed means a 1.
    logic [DIGITS-1:0]  dots;         // switch pressed means dot on.
    logic               shift_strobe; // slow strobe for shifting and counting.
    logic               scan_strobe;  // fast strobe for the display scan.
    logic [SHIFT_W-1:0] out_reg;      // bit 0 is the newest bit.
    logic               moore_y;
    logic               mealy_y;
    display_word_t      display_word; // strobe, moore and mealy counts.

    // **************************************************
    // board polarity, keys and switches are active low
    // **************************************************

    assign serial_bit = ~i_key[1];
    assign dots       = ~i_sw;
    assign o_led      = ~out_reg; // a stored 1 lights its led.
    assign o_buzzer   = i_key[0]; // buzzer sounds while key 0 is held.

    strobe_gen #(.W(SHIFT_STROBE_W)) i_shift_strobe (
        .i_clk    (clk),
        .i_arst_n (i_arst_n),
        .o_strobe (shift_strobe)
    );

    shift_register i_shift_reg (
        .i_clk     (clk),
        .i_arst_n  (i_arst_n),
        .i_en      (shift_strobe),
        .i_in      (serial_bit),
        .o_out_reg (out_reg)
    );

    moore_fsm i_moore_fsm (
        .i_clk    (clk),
        .i_arst_n (i_arst_n),
        .i_en     (shift_strobe),
        .i_a      (out_reg[0]), // detectors see a bit one strobe after it is stored.
        .o_y      (moore_y)
    );

    mealy_fsm i_mealy_fsm (
        .i_clk    (clk),
        .i_arst_n (i_arst_n),
        .i_en     (shift_strobe),
        .i_a      (out_reg[0]),
        .o_y      (mealy_y)
    );

    event_counters i_event_counters (
        .i_clk     (clk),
        .i_arst_n  (i_arst_n),
        .i_en      (shift_strobe),
        .i_moore_y (moore_y),
        .i_mealy_y (mealy_y),
        .o_word    (display_word)
    );

    strobe_gen #(.W(SCAN_STROBE_W)) i_scan_strobe (
        .i_clk    (clk),
        .i_arst_n (i_arst_n),
        .o_strobe (scan_strobe)
    );

    seven_segment i_seven_segment (
        .i_clk     (clk),
        .i_arst_n  (i_arst_n),
        .i_en      (scan_strobe),
        .i_word    (display_word),
        .i_dots    (dots),
        .o_abcdefg (o_abcdefgh[7:1]), // segment a sits in the msb.
        .o_dot     (o_abcdefgh[0]),
        .o_anodes  (o_digit)
    );

endmodule

// File: verification/tb_lab_top.sv
`timescale 1ns/10ps

module tb_lab_top;

    import lab_pkg::*;

    localparam int ROWS     = 16; // eleven sequence rows, then random ones.
    localparam int SEQ_ROWS = 11;
    localparam int PERIOD   = 32; // shift strobe period with a width of 5.
    localparam int FIRST    = 49; // edge count of the first shift strobe.
    localparam int LIMIT    = 16 + ROWS * 32 + ROWS * 8 * 4 * 2 + 200;
    // active high a..g patterns for 0..f, with lower case b and d.
    localparam logic [6:0] HEX_SEG [16] = '{7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b,
        7'h5f, 7'h70, 7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47};

    typedef struct packed {
        logic       key0; // raw level, the buzzer follows it.
        logic       key1; // raw level, low shifts in a 1.
        logic [7:0] sw;   // raw levels, low lights the dot.
        logic       show; // scan the display after this row.
    } row_t;

    logic               clk;
    logic               arst_n;
    logic [3:0]         key;
    logic [7:0]         sw;
    logic [SHIFT_W-1:0] led;
    logic [7:0]         abcdefgh;
    logic [7:0]         digit;
    logic               buzzer;
    row_t               rows [ROWS];
    string              names [ROWS];
    int                 cycle_count = 0;
    int                 errors;
    int                 tests_failed;
    integer             seed;
    logic [SHIFT_W-1:0] m_reg;  // model of the shift register.
    display_word_t      m_word; // model of the three counters.

    lab_top #(.SHIFT_STROBE_W(5), .SCAN_STROBE_W(2)) i_dut (
        .clk        (clk),
        .i_arst_n   (arst_n),
        .i_key      (key),
        .i_sw       (sw),
        .o_led      (led),
        .o_abcdefgh (abcdefgh),
        .o_digit    (digit),
        .o_buzzer   (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period.
    end

    always @(posedge clk) cycle_count <= cycle_count + 1; // edges since time zero.

    initial begin
        wait (cycle_count >= LIMIT);
        $display("timeout: the simulation did not finish");
        $display("Checks failed");
        $finish;
    end

    // **************************************************
    // compare tasks and helpers
    // **************************************************

    task automatic check_led(input string name, input logic [SHIFT_W-1:0] exp,
                             input logic [SHIFT_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s led expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input display_word_t exp,
                              input logic [2:0] idx, input logic [3:0] act);
        logic [31:0] flat;
        logic [3:0]  exp_nib;
        flat    = exp;
        exp_nib = 4'(flat >> (idx * 4)); // digit i shows nibble i.
        if (act !== exp_nib) begin
            errors++;
            $display("FAIL %s digit %0d expected %h actual %h", name, idx, exp_nib, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic wait_cycle(input int target);
        while (cycle_count < target) begin
            @(posedge clk);
            #2; // sample and drive away from the edge.
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errors - errors_before);
        end
    endtask

    // the detectors see the stored newest bit, so their state follows from
    // the history one position back in the register.
    task automatic model_strobe(input logic new_bit);
        moore_state_t moore_st;
        mealy_state_t mealy_st;
        moore_st = (m_reg[3:1] == 3'b101) ? MOORE_GOT_101 :
                   (m_reg[2:1] == 2'b10)  ? MOORE_GOT_10  :
                   m_reg[1]               ? MOORE_GOT_1   : MOORE_IDLE;
        mealy_st = (m_reg[2:1] == 2'b10)  ? MEALY_GOT_10  :
                   m_reg[1]               ? MEALY_GOT_1   : MEALY_IDLE;
        m_word.strobe_count = m_word.strobe_count + STROBE_CNT_W'(1);
        m_word.moore_count  = m_word.moore_count + FSM_CNT_W'(moore_st == MOORE_GOT_101);
        m_word.mealy_count  = m_word.mealy_count
                            + FSM_CNT_W'((mealy_st == MEALY_GOT_10) && m_reg[0]);
        m_reg = {m_reg[SHIFT_W-2:0], new_bit}; // the oldest bit drops out.
    endtask

    // follows the scan from whichever digit is lit, one anode after another.
    task automatic check_display(input string name, input logic [7:0] sw_now);
        int         first;
        logic [2:0] d;
        logic [4:0] hex;
        first = -1;
        wait_cycle(cycle_count + 1); // segments pick up the new word one edge later.
        for (int i = 0; i < DIGITS; i++) begin
            if (digit === ~(DIGITS'(1) << i)) first = i;
        end
        if (first < 0) begin
            errors++;
            $display("%s: no digit is selected on the display", name);
            return;
        end
        for (int j = 0; j < DIGITS; j++) begin
            d = 3'(first + j); // wraps from 7 to 0.
            while (digit !== ~(DIGITS'(1) << d)) wait_cycle(cycle_count + 1);
            hex = 5'h10; // stays invalid unless a pattern matches.
            for (int v = 0; v < 16; v++) begin
                if (~abcdefgh[7:1] === HEX_SEG[v]) hex = 5'(v);
            end
            if (hex[4]) begin
                errors++;
                $display("%s: digit %0d shows a pattern that is no hex digit", name, d);
            end else begin
                check_word(name, m_word, d, hex[3:0]);
            end
            check_bit({name, " dot"}, sw_now[d], abcdefgh[0]); // pressed switch, dot low.
        end
    endtask

    task automatic fill_table();
        logic seq [SEQ_ROWS] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1,
                                 1'b0, 1'b1};
        for (int k = 0; k < ROWS; k++) begin
            if (k < SEQ_ROWS) begin
                rows[k] = '{key0: 1'(k), key1: !seq[k], sw: 8'ha5 ^ 8'(k),
                            show: (k == 3 || k == SEQ_ROWS - 1)};
                names[k] = $sformatf("seq_%0d", k);
            end else begin
                rows[k] = '{key0: 1'($random(seed)), key1: 1'($random(seed)),
                            sw: 8'($random(seed)), show: (k == ROWS - 1)};
                names[k] = $sformatf("rand_%0d", k);
            end
        end
    endtask

    // **************************************************
    // main sequence
    // **************************************************

    initial begin
        int fails_before;
        seed         = 32'h3e21;
        errors       = 0;
        tests_failed = 0;
        arst_n       = 1'b0;
        key          = 4'hf; // keys released.
        sw           = 8'hff; // switches off.
        m_reg        = '0;
        m_word       = '0;
        fill_table();
        wait_cycle(16);
        arst_n = 1'b1; // 16 edges under reset.
        fails_before = errors;
        wait_cycle(17);
        check_led("reset", '1, led);
        check_bit("reset anodes", 1'b1, &digit); // dark until the first scan strobe.
        check_bit("reset buzzer", 1'b1, buzzer);
        key[0] = 1'b0;
        #1;
        check_bit("reset buzzer", 1'b0, buzzer);
        report_test("reset", fails_before);
        for (int k = 0; k < ROWS; k++) begin
            fails_before = errors;
            key[1] = rows[k].key1;
            key[0] = rows[k].key0;
            sw     = rows[k].sw;
            wait_cycle(FIRST + k * PERIOD); // the strobe that takes this row.
            model_strobe(!rows[k].key1);
            check_led(names[k], ~m_reg, led);
            check_bit({names[k], " buzzer"}, rows[k].key0, buzzer);
            if (rows[k].show) check_display(names[k], rows[k].sw);
            report_test(names[k], fails_before);
        end
        $display("tests run %0d, tests with errors %0d, mismatches %0d", ROWS + 1,
                 tests_failed, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: src.f
source/lab_pkg.sv
source/strobe_gen.sv
source/shift_register.sv
source/moore_fsm.sv
source/mealy_fsm.sv
source/event_counters.sv
source/seven_segment.sv
source/lab_top.sv
verification/tb_lab_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the fail message.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/10ps -f src.f --top-module tb_lab_top \
        > build.log 2>&1; then
    cat build.log
    echo "build error, see build.log"
    exit 1
fi

./obj_dir/Vtb_lab_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0
